// ==== rtl/dac_params.svh ====
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

////////////////////////////////////////
// dac instruction geometry
////////////////////////////////////////

// one channel value, as the dac takes it
`define DAC_W_DATA	16

// channel number, the address MSB is reserved for broadcast
`define DAC_W_CHS	3

// channels on the part
`define DAC_N_CHAN	8

// prefix + command + address + data + feature
`define DAC_INSTR_W	32

`endif

// ==== rtl/dac_pkg.sv ====
package dac_pkg;

	////////////////////////////////////////
	// serial controller
	////////////////////////////////////////

	typedef enum logic [2:0] {
		st_idle,		// wait for a request
		st_sync_data,	// nsync low, write instruction loads next
		st_sync_ref,	// nsync low, reference instruction loads next
		st_tx,			// 32 bits out on sclk
		st_dac_done		// one-cycle done strobe
	} dac_state_t;

	// command nibble of the instruction
	typedef enum logic [3:0] {
		cmd_write_update	= 4'b0011,	// write selected register and update its output
		cmd_set_ref			= 4'b1001	// reference setup register
	} dac_cmd_t;

	////////////////////////////////////////
	// update sequencer
	////////////////////////////////////////

	typedef enum logic [1:0] {
		seq_idle,	// forward ref requests, wait for start
		seq_issue,	// data_valid for the current channel
		seq_wait	// wait for the controller's done
	} seq_state_t;

endpackage

// ==== rtl/dac_serial_controller.sv ====
`timescale 1ns/1ps

`include "dac_params.svh"

module dac_serial_controller (
	input  logic						clk_in,
	input  logic						reset_in,

	// requests from the sequencer
	input  logic						ref_set,		// set internal reference
	input  logic						data_valid,		// write + update one channel
	input  logic [`DAC_W_DATA-1:0]		data,
	input  logic [`DAC_W_CHS-1:0]		channel,

	// dac pins
	output logic						nldac_out,		// tied low, outputs follow the write
	output logic						nsync_out,		// frame, active low
	output logic						sclk_out,		// gated clk_in
	output logic						din_out,		// serial data, MSB first
	output logic						nclr_out,		// tied high, no clear

	// status
	output logic						dac_done_out,	// one pulse per operation
	output logic [`DAC_W_DATA-1:0]		data_out,		// last latched value
	output logic [`DAC_W_CHS-1:0]		channel_out		// last latched channel
);

	import dac_pkg::*;

	////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////

	// write-update frame
	localparam logic [3:0] wr_prefix	= 4'b0000;
	localparam logic [3:0] wr_feature	= 4'b0000;

	// reference frame, internal reference always on
	localparam logic [3:0]	ref_prefix	= 4'b0000;
	localparam logic [3:0]	ref_addr	= 4'b0000;
	localparam logic [3:0]	ref_feature	= 4'b1010;
	localparam logic [15:0]	ref_data	= 16'h0000;

	localparam int unsigned tx_last = `DAC_INSTR_W - 1;	// counter value of the last bit

	dac_state_t					cur_state;
	dac_state_t					next_state;
	logic [5:0]					counter;		// cycles spent in the current state

	logic [`DAC_W_CHS:0]		address;		// msb stays 0, no broadcast
	logic [`DAC_W_DATA-1:0]		data_lat;
	logic [`DAC_INSTR_W-1:0]	data_instr;
	logic [`DAC_INSTR_W-1:0]	ref_instr;
	logic [`DAC_INSTR_W-1:0]	tx_data;		// shift register, bit 31 on the pin
	logic						sclk_en;

	////////////////////////////////////////
	// pins and status
	////////////////////////////////////////

	assign nclr_out		= 1'b1;
	assign nldac_out	= 1'b0;

	assign data_instr	= {wr_prefix, cmd_write_update, address, data_lat, wr_feature};
	assign ref_instr	= {ref_prefix, cmd_set_ref, ref_addr, ref_feature, ref_data};

	assign nsync_out	= (cur_state == st_idle);		// low for the whole operation
	assign sclk_out		= sclk_en ? clk_in : 1'b1;	// parks high between frames
	assign din_out		= tx_data[`DAC_INSTR_W-1];

	assign dac_done_out	= (cur_state == st_dac_done);
	assign data_out		= data_lat;
	assign channel_out	= address[`DAC_W_CHS-1:0];

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	// clock gate enable, on for exactly the tx cycles
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sclk_en <= 1'b0;
		end else if ((cur_state == st_sync_data) || (cur_state == st_sync_ref)) begin
			sclk_en <= 1'b1;
		end else if ((cur_state == st_tx) && (counter == tx_last[5:0])) begin
			sclk_en <= 1'b0;	// last bit done
		end
	end

	// latch channel and value when a write is accepted
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_lat	<= '0;
			address		<= '0;
		end else if ((cur_state == st_idle) && data_valid) begin
			data_lat	<= data;
			address		<= {1'b0, channel};
		end
	end

	// shift register
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			tx_data <= '0;
		end else begin
			case (cur_state)
				st_idle:		tx_data <= '0;		// din rests low
				st_sync_data:	tx_data <= data_instr;
				st_sync_ref:	tx_data <= ref_instr;
				st_tx:			tx_data <= tx_data << 1;
				default:		tx_data <= tx_data;
			endcase
		end
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cur_state <= st_idle;
		end else begin
			cur_state <= next_state;
		end
	end

	// restarts on every state change
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			counter <= '0;
		end else if (cur_state != next_state) begin
			counter <= '0;
		end else begin
			counter <= counter + 1'b1;	// free runs in idle, unused there
		end
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			st_idle: begin
				if (data_valid) begin
					next_state = st_sync_data;	// data wins a tie
				end else if (ref_set) begin
					next_state = st_sync_ref;
				end
			end
			st_sync_data:	next_state = st_tx;
			st_sync_ref:	next_state = st_tx;
			st_tx: begin
				if (counter == tx_last[5:0]) begin
					next_state = st_dac_done;
				end
			end
			st_dac_done:	next_state = st_idle;
			default:		next_state = st_idle;
		endcase
	end

endmodule

// ==== rtl/update_sequencer.sv ====
`timescale 1ns/1ps

`include "dac_params.svh"

module update_sequencer (
	input  logic					clk_in,
	input  logic					reset_in,

	// host side
	input  logic					wr_en,			// table write strobe
	input  logic [`DAC_W_CHS-1:0]	wr_channel,
	input  logic [`DAC_W_DATA-1:0]	wr_data,
	input  logic					start_in,		// one sweep over all channels
	input  logic					ref_set_in,		// reference request, held until forwarded

	// serial controller side
	input  logic					dac_done,
	output logic					data_valid,
	output logic [`DAC_W_DATA-1:0]	data,
	output logic [`DAC_W_CHS-1:0]	channel,
	output logic					ref_set,

	// status
	output logic					busy_out,		// sweep running
	output logic					sweep_done_out	// pulse after the last channel
);

	import dac_pkg::*;

	localparam logic [`DAC_W_CHS-1:0] last_chan = `DAC_W_CHS'(`DAC_N_CHAN - 1);

	seq_state_t				state;
	logic [`DAC_W_DATA-1:0]	chan_tab [`DAC_N_CHAN];	// host written values
	logic [`DAC_W_CHS-1:0]	chan_idx;
	logic					start_pend;
	logic					ref_pend;
	logic					ref_busy;		// seq_wait is closing a ref op
	logic					ref_fwd;		// ref request leaves this cycle
	logic					sweep_begin;

	// table read is live, late writes still make it out
	assign data_valid	= (state == seq_issue);
	assign data			= chan_tab[chan_idx];
	assign channel		= chan_idx;

	// ref goes first whenever idle
	assign ref_fwd		= (state == seq_idle) && ref_pend;
	assign sweep_begin	= (state == seq_idle) && !ref_pend && (start_in || start_pend);

	////////////////////////////////////////
	// value table
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			for (int i = 0; i < `DAC_N_CHAN; i++) begin
				chan_tab[i] <= '0;
			end
		end else if (wr_en) begin
			chan_tab[wr_channel] <= wr_data;
		end
	end

	////////////////////////////////////////
	// request flags
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			ref_pend	<= 1'b0;
			start_pend	<= 1'b0;
		end else begin
			ref_pend	<= (ref_pend && !ref_fwd) || ref_set_in;	// new pulse re-arms
			start_pend	<= (start_pend || (start_in && !busy_out)) && !sweep_begin;
		end
	end

	////////////////////////////////////////
	// sweep control
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state			<= seq_idle;
			chan_idx		<= '0;
			ref_set			<= 1'b0;
			ref_busy		<= 1'b0;
			busy_out		<= 1'b0;
			sweep_done_out	<= 1'b0;
		end else begin
			ref_set			<= 1'b0;	// strobes default low
			sweep_done_out	<= 1'b0;
			case (state)
				seq_idle: begin
					if (ref_fwd) begin
						ref_set		<= 1'b1;
						ref_busy	<= 1'b1;
						state		<= seq_wait;
					end else if (sweep_begin) begin
						chan_idx	<= '0;
						busy_out	<= 1'b1;
						state		<= seq_issue;
					end
				end
				seq_issue: begin
					state <= seq_wait;	// data_valid was up for one cycle
				end
				seq_wait: begin
					if (dac_done) begin
						if (ref_busy) begin
							ref_busy	<= 1'b0;	// no sweep_done for ref ops
							state		<= seq_idle;
						end else if (chan_idx == last_chan) begin
							busy_out		<= 1'b0;
							sweep_done_out	<= 1'b1;
							state			<= seq_idle;
						end else begin
							chan_idx	<= chan_idx + 1'b1;
							state		<= seq_issue;
						end
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

// ==== rtl/dac_subsystem.sv ====
`timescale 1ns/1ps

`include "dac_params.svh"

module dac_subsystem (
	input  logic					clk_in,
	input  logic					reset_in,

	// host
	input  logic					wr_en,
	input  logic [`DAC_W_CHS-1:0]	wr_channel,
	input  logic [`DAC_W_DATA-1:0]	wr_data,
	input  logic					start_in,
	input  logic					ref_set_in,

	// dac pins
	output logic					nldac_out,
	output logic					nsync_out,
	output logic					sclk_out,
	output logic					din_out,
	output logic					nclr_out,

	// status back to host
	output logic					dac_done_out,
	output logic [`DAC_W_DATA-1:0]	data_out,
	output logic [`DAC_W_CHS-1:0]	channel_out,
	output logic					busy_out,
	output logic					sweep_done_out
);

	////////////////////////////////////////
	// sequencer to controller
	////////////////////////////////////////

	logic					data_valid;
	logic [`DAC_W_DATA-1:0]	data;
	logic [`DAC_W_CHS-1:0]	channel;
	logic					ref_set;

	update_sequencer u_sequencer (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.wr_en			(wr_en),
		.wr_channel		(wr_channel),
		.wr_data		(wr_data),
		.start_in		(start_in),
		.ref_set_in		(ref_set_in),
		.dac_done		(dac_done_out),		// closes each request
		.data_valid		(data_valid),
		.data			(data),
		.channel		(channel),
		.ref_set		(ref_set),
		.busy_out		(busy_out),
		.sweep_done_out	(sweep_done_out)
	);

	dac_serial_controller u_dac (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.ref_set		(ref_set),
		.data_valid		(data_valid),
		.data			(data),
		.channel		(channel),
		.nldac_out		(nldac_out),
		.nsync_out		(nsync_out),
		.sclk_out		(sclk_out),
		.din_out		(din_out),
		.nclr_out		(nclr_out),
		.dac_done_out	(dac_done_out),
		.data_out		(data_out),
		.channel_out	(channel_out)
	);

endmodule

// ==== dv/dac_subsystem_asserts.sv ====
`timescale 1ns/1ps

module dac_subsystem_asserts (
	input logic					clk_in,
	input logic					reset_in,
	input dac_pkg::dac_state_t	cur_state,
	input logic					nsync_out,
	input logic					sclk_out,
	input logic					dac_done_out,
	input logic					data_valid
);

	import dac_pkg::*;

	// a frame opens into exactly one sync state
	sync_entry: assert property (@(posedge clk_in) disable iff (reset_in)
		$fell(nsync_out) |-> (cur_state inside {st_sync_data, st_sync_ref}))
		else $error("nsync fell without idle to sync transition");

	done_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		dac_done_out |=> !dac_done_out)
		else $error("dac_done longer than one cycle");

	// low half of clk_in, sclk must be parked outside a frame
	sclk_parked: assert property (@(posedge clk_in) disable iff (reset_in)
		nsync_out |-> sclk_out)
		else $error("sclk toggled outside a frame");

	req_in_idle: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid |-> (cur_state == st_idle))
		else $error("data_valid while controller busy");

endmodule

bind dac_serial_controller dac_subsystem_asserts u_asserts (
	.clk_in			(clk_in),
	.reset_in		(reset_in),
	.cur_state		(cur_state),
	.nsync_out		(nsync_out),
	.sclk_out		(sclk_out),
	.dac_done_out	(dac_done_out),
	.data_valid		(data_valid)
);

// ==== dv/dac_subsystem_tb.sv ====
`timescale 1ns/1ps

`include "dac_params.svh"

module dac_subsystem_tb;

	import dac_pkg::*;

	localparam time			clk_period	= 100;
	localparam int unsigned	seed		= 32'h57e4c474;
	localparam int			max_wait	= 400;						// cycles per wait loop
	localparam int			frame_low	= 1 + `DAC_INSTR_W + 1;	// sync + tx + done

	// fixed instruction fields
	localparam logic [3:0]	fr_prefix	= 4'b0000;
	localparam logic [3:0]	fr_wr_feat	= 4'b0000;
	localparam logic [3:0]	fr_ref_addr	= 4'b0000;
	localparam logic [3:0]	fr_ref_feat	= 4'b1010;		// internal reference on
	localparam logic [15:0]	fr_ref_data	= 16'h0000;

	typedef enum logic [1:0] {op_write, op_start, op_ref, op_ref_mid} op_t;

	typedef struct packed {
		op_t					op;
		logic [`DAC_W_CHS-1:0]	ch;
		logic [`DAC_W_DATA-1:0]	val;
		int						n_frames;	// frames the row has to produce
	} row_t;

	localparam int n_rows = `DAC_N_CHAN + 5;

	logic					clk_in;
	logic					reset_in;
	logic					wr_en;
	logic [`DAC_W_CHS-1:0]	wr_channel;
	logic [`DAC_W_DATA-1:0]	wr_data;
	logic					start_in;
	logic					ref_set_in;
	logic					nldac_out;
	logic					nsync_out;
	logic					sclk_out;
	logic					din_out;
	logic					nclr_out;
	logic					dac_done_out;
	logic [`DAC_W_DATA-1:0]	data_out;
	logic [`DAC_W_CHS-1:0]	channel_out;
	logic					busy_out;
	logic					sweep_done_out;

	row_t						stim [n_rows];
	logic [`DAC_W_DATA-1:0]		model_tab [`DAC_N_CHAN];	// mirror of the host table
	logic [`DAC_W_DATA-1:0]		last_val;					// readback after the last data op
	logic [`DAC_W_CHS-1:0]		last_ch;
	logic [`DAC_INSTR_W-1:0]	frame_q [$];
	int							bits_q [$];
	int							low_q [$];
	logic [`DAC_INSTR_W-1:0]	shift_reg	= '0;
	int							bit_cnt		= 0;
	logic						in_frame	= 1'b0;
	time						fall_t		= 0;

	dac_subsystem u_dut (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.wr_en			(wr_en),
		.wr_channel		(wr_channel),
		.wr_data		(wr_data),
		.start_in		(start_in),
		.ref_set_in		(ref_set_in),
		.nldac_out		(nldac_out),
		.nsync_out		(nsync_out),
		.sclk_out		(sclk_out),
		.din_out		(din_out),
		.nclr_out		(nclr_out),
		.dac_done_out	(dac_done_out),
		.data_out		(data_out),
		.channel_out	(channel_out),
		.busy_out		(busy_out),
		.sweep_done_out	(sweep_done_out)
	);

	always #(clk_period / 2) clk_in = ~clk_in;

	////////////////////////////////////////
	// serial frame capture
	////////////////////////////////////////

	// din is taken on falling sclk, the frame closes when nsync rises
	always @(negedge sclk_out or negedge nsync_out or posedge nsync_out) begin
		if (!nsync_out && in_frame) begin
			shift_reg	= {shift_reg[`DAC_INSTR_W-2:0], din_out};
			bit_cnt		= bit_cnt + 1;
		end else if (!nsync_out) begin
			in_frame	= 1'b1;		// nsync just fell, sclk is still parked
			fall_t		= $time;
			bit_cnt		= 0;
		end else if (in_frame) begin
			frame_q.push_back(shift_reg);
			bits_q.push_back(bit_cnt);
			low_q.push_back(int'(($time - fall_t) / clk_period));
			in_frame	= 1'b0;
		end
	end

	////////////////////////////////////////
	// failure reporting and compare tasks
	////////////////////////////////////////

	task automatic stop_on_mismatch(input string msg);
		$display("Fail %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "wrong value");
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout, no %s within %0d clock cycles", what, max_wait);
		$display("TEST FAILED");
		$fatal(1, "wait loop timed out");
	endtask

	task automatic check_frame(input logic [`DAC_INSTR_W-1:0] frame, input dac_cmd_t cmd,
			input logic [`DAC_W_CHS-1:0] ch, input logic [`DAC_W_DATA-1:0] val);
		logic [`DAC_INSTR_W-1:0] want;
		if (cmd == cmd_set_ref) begin
			want = {fr_prefix, cmd, fr_ref_addr, fr_ref_feat, fr_ref_data};
		end else begin
			want = {fr_prefix, cmd, 1'b0, ch, val, fr_wr_feat};	// addr msb 0, no broadcast
		end
		if (frame !== want) begin
			stop_on_mismatch($sformatf("frame %h, expected %h", frame, want));
		end
	endtask

	task automatic check_readback(input logic [`DAC_W_DATA-1:0] got_val,
			input logic [`DAC_W_CHS-1:0] got_ch, input logic [`DAC_W_DATA-1:0] want_val,
			input logic [`DAC_W_CHS-1:0] want_ch);
		if ((got_val !== want_val) || (got_ch !== want_ch)) begin
			stop_on_mismatch($sformatf("readback ch %0d val %h, expected ch %0d val %h",
				got_ch, got_val, want_ch, want_val));
		end
	endtask

	task automatic check_count(input int got, input int want, input string what);
		if (got != want) begin
			stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, want));
		end
	endtask

	task automatic check_level(input logic got, input logic want, input string what);
		if (got !== want) begin
			stop_on_mismatch($sformatf("%s is %b, expected %b", what, got, want));
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	function automatic row_t make_row(input op_t op, input logic [`DAC_W_CHS-1:0] ch,
			input logic [`DAC_W_DATA-1:0] val, input int n_frames);
		row_t row;
		row.op			= op;
		row.ch			= ch;
		row.val			= val;
		row.n_frames	= n_frames;
		return row;
	endfunction

	task automatic fill_table();
		logic [`DAC_W_CHS-1:0]	rw_ch;
		logic [`DAC_W_DATA-1:0]	rw_val;
		for (int i = 0; i < `DAC_N_CHAN; i++) begin
			stim[i] = make_row(op_write, `DAC_W_CHS'(i), `DAC_W_DATA'($urandom()), 0);
		end
		stim[`DAC_N_CHAN]		= make_row(op_start, '0, '0, `DAC_N_CHAN);
		stim[`DAC_N_CHAN + 1]	= make_row(op_ref, '0, '0, 1);
		stim[`DAC_N_CHAN + 2]	= make_row(op_ref_mid, '0, '0, `DAC_N_CHAN + 1);
		rw_ch	= `DAC_W_CHS'($urandom());
		rw_val	= stim[int'(rw_ch)].val ^ (`DAC_W_DATA'($urandom()) | 16'h0001);	// never equal
		stim[`DAC_N_CHAN + 3]	= make_row(op_write, rw_ch, rw_val, 0);
		stim[`DAC_N_CHAN + 4]	= make_row(op_start, '0, '0, `DAC_N_CHAN);
	endtask

	// all drivers start and end on a falling edge
	task automatic write_entry(input logic [`DAC_W_CHS-1:0] ch, input logic [`DAC_W_DATA-1:0] val);
		wr_en		= 1'b1;
		wr_channel	= ch;
		wr_data		= val;
		@(negedge clk_in);
		wr_en		= 1'b0;
		model_tab[ch] = val;
	endtask

	task automatic pulse_start();
		start_in = 1'b1;
		@(negedge clk_in);
		start_in = 1'b0;
	endtask

	task automatic pulse_ref();
		ref_set_in = 1'b1;
		@(negedge clk_in);
		ref_set_in = 1'b0;
	endtask

	task automatic wait_frames(input int n, input string what);
		int cycles;
		cycles = 0;
		while (frame_q.size() < n) begin
			cycles++;
			if (cycles > max_wait) stop_on_timeout(what);
			@(negedge clk_in);
		end
	endtask

	// one sweep up to sweep_done, ref_after < 0 means no ref request
	task automatic run_sweep(input int ref_after);
		int cycles;
		int dones;
		cycles	= 0;
		dones	= 0;
		pulse_start();
		while (!sweep_done_out) begin
			ref_set_in = 1'b0;
			check_level(busy_out, 1'b1, "busy_out during sweep");
			if (dac_done_out) begin
				check_readback(data_out, channel_out, model_tab[dones], `DAC_W_CHS'(dones));
				dones++;
				ref_set_in = (dones == ref_after);	// one pulse mid sweep
			end
			cycles++;
			if (cycles > max_wait) stop_on_timeout("sweep_done_out pulse");
			@(negedge clk_in);
		end
		ref_set_in = 1'b0;
		check_count(dones, `DAC_N_CHAN, "dac_done pulses in a sweep");
		last_val	= model_tab[`DAC_N_CHAN - 1];
		last_ch		= `DAC_W_CHS'(`DAC_N_CHAN - 1);
	endtask

	task automatic check_sweep_frames();
		for (int i = 0; i < `DAC_N_CHAN; i++) begin
			check_frame(frame_q.pop_front(), cmd_write_update, `DAC_W_CHS'(i), model_tab[i]);
			check_count(bits_q.pop_front(), `DAC_INSTR_W, "sclk falling edges in a frame");
			check_count(low_q.pop_front(), frame_low, "nsync low cycles in a frame");
		end
	endtask

	task automatic check_ref_frame();
		check_count(frame_q.size(), 1, "reference frames");
		check_frame(frame_q.pop_front(), cmd_set_ref, '0, '0);
		check_count(bits_q.pop_front(), `DAC_INSTR_W, "sclk falling edges in a frame");
		check_count(low_q.pop_front(), frame_low, "nsync low cycles in a frame");
		check_readback(data_out, channel_out, last_val, last_ch);	// ref leaves them alone
		for (int i = 0; i < 2 * frame_low; i++) begin
			@(negedge clk_in);
			check_level(nsync_out, 1'b1, "nsync_out after the reference frame");
		end
	endtask

	initial begin
		clk_in		= 1'b0;
		reset_in	= 1'b1;
		wr_en		= 1'b0;
		wr_channel	= '0;
		wr_data		= '0;
		start_in	= 1'b0;
		ref_set_in	= 1'b0;
		void'($urandom(seed));
		for (int i = 0; i < `DAC_N_CHAN; i++) begin
			model_tab[i] = '0;		// table is zero after reset
		end
		last_val	= '0;
		last_ch		= '0;
		fill_table();
		repeat (3) @(posedge clk_in);
		@(negedge clk_in);
		reset_in = 1'b0;

		// idle pins straight after reset
		check_level(nsync_out, 1'b1, "nsync_out after reset");
		check_level(sclk_out, 1'b1, "sclk_out after reset");
		check_level(nclr_out, 1'b1, "nclr_out after reset");
		check_level(nldac_out, 1'b0, "nldac_out after reset");
		check_level(din_out, 1'b0, "din_out after reset");
		check_level(dac_done_out, 1'b0, "dac_done_out after reset");
		check_level(busy_out, 1'b0, "busy_out after reset");
		check_level(sweep_done_out, 1'b0, "sweep_done_out after reset");

		for (int r = 0; r < n_rows; r++) begin
			case (stim[r].op)
				op_write:	write_entry(stim[r].ch, stim[r].val);
				op_start: begin
					run_sweep(-1);
					check_count(frame_q.size(), stim[r].n_frames, "frames per sweep");
					check_sweep_frames();
				end
				op_ref: begin
					pulse_ref();
					wait_frames(stim[r].n_frames, "reference frame");
					check_ref_frame();
				end
				op_ref_mid: begin
					run_sweep(`DAC_N_CHAN / 2);
					check_count(frame_q.size(), `DAC_N_CHAN, "data frames before sweep_done");
					check_sweep_frames();
					wait_frames(stim[r].n_frames - `DAC_N_CHAN, "deferred reference frame");
					check_ref_frame();
				end
				default: ;
			endcase
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/dac_pkg.sv
rtl/dac_serial_controller.sv
rtl/update_sequencer.sv
rtl/dac_subsystem.sv
dv/dac_subsystem_asserts.sv
dv/dac_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator and run, exit status follows the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dac_subsystem_tb -Mdir obj_dir -f vlog.f \
	&& ./obj_dir/Vdac_subsystem_tb \
	|| { echo "build or simulation failed" >&2; exit 1; }

echo "simulation passed"
exit 0
